// ==== rtl/quant_consts.svh ====
`ifndef QUANT_CONSTS_SVH
`define QUANT_CONSTS_SVH

// coefficient and result width.
`define QUANT_COEF_W 16

// largest legal qp.
`define QUANT_QP_MAX 51

// forward rounding numerators, scaled by the block shift.
`define QUANT_RND_INTRA 171
`define QUANT_RND_INTER 85

`endif

// ==== rtl/quant_pkg.sv ====
`include "quant_consts.svh"

package quant_pkg;

  typedef logic signed [`QUANT_COEF_W-1:0] coef_t;
  typedef logic [5:0]  qp_t;
  // 0 is 4x4, 3 is 32x32.
  typedef logic [1:0]  tsize_t;
  typedef logic [15:0] scale_t;
  typedef logic [27:0] offset_t;
  typedef logic [4:0]  shift_t;

  typedef enum logic {
    idle,
    reduce
  } qp_state_e;

  typedef enum logic {
    wait_req,
    wait_release
  } hs_state_e;

endpackage

// ==== rtl/quant_param_if.sv ====
interface quant_param_if;

  quant_pkg::scale_t  scale;
  quant_pkg::offset_t offset;
  quant_pkg::shift_t  shift;
  logic               inverse;
  // high while the block parameters are valid.
  logic               ready;

  modport source (
    output scale,
    output offset,
    output shift,
    output inverse,
    output ready
  );

  modport sink (input scale, input offset, input shift, input inverse);

  modport monitor (input ready);

endinterface

// ==== rtl/qp_scale_gen.sv ====
`include "quant_consts.svh"

module qp_scale_gen (
  input  logic              clk,
  input  logic              rst,
  input  logic              i_load,
  input  quant_pkg::qp_t    i_qp,
  input  quant_pkg::tsize_t i_tsize,
  input  logic              i_inter,
  input  logic              i_inverse,
  quant_param_if.source     prm
);

  quant_pkg::qp_state_e state;
  quant_pkg::qp_t       rem;
  logic [3:0]           per;
  quant_pkg::tsize_t    tsize;
  logic                 inter;
  logic                 inverse;
  logic                 start;
  logic                 done;
  quant_pkg::shift_t    fwd_shift;
  logic [8:0]           rnd;

  function automatic quant_pkg::scale_t fwd_scale(input logic [2:0] r);
    case (r)
      3'd0:    fwd_scale = 16'd26214;
      3'd1:    fwd_scale = 16'd23302;
      3'd2:    fwd_scale = 16'd20560;
      3'd3:    fwd_scale = 16'd18396;
      3'd4:    fwd_scale = 16'd16384;
      default: fwd_scale = 16'd14564;
    endcase
  endfunction

  function automatic quant_pkg::scale_t inv_scale(input logic [2:0] r);
    case (r)
      3'd0:    inv_scale = 16'd40;
      3'd1:    inv_scale = 16'd45;
      3'd2:    inv_scale = 16'd51;
      3'd3:    inv_scale = 16'd57;
      3'd4:    inv_scale = 16'd64;
      default: inv_scale = 16'd72;
    endcase
  endfunction

  assign start = (state == quant_pkg::idle) && i_load;
  // remainder below 6 means rem is qp%6 and per is qp/6.
  assign done  = (state == quant_pkg::reduce) && (rem < 6'd6);

  assign fwd_shift = 5'd19 - 5'(tsize) + 5'(per);
  assign rnd       = inter ? 9'(`QUANT_RND_INTER) : 9'(`QUANT_RND_INTRA);

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      state     <= quant_pkg::idle;
      rem       <= '0;
      per       <= '0;
      prm.ready <= 1'b0;
    end else begin
      if (start) begin
        rem       <= i_qp;
        per       <= '0;
        prm.ready <= 1'b0;
        state     <= quant_pkg::reduce;
      end else if (done) begin
        prm.ready <= 1'b1;
        state     <= quant_pkg::idle;
      end else if (state == quant_pkg::reduce) begin
        rem <= rem - 6'd6;
        per <= per + 4'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      tsize   <= i_tsize;
      inter   <= i_inter;
      inverse <= i_inverse;
    end
    if (done) begin
      prm.inverse <= inverse;
      if (inverse) begin
        prm.scale  <= inv_scale(rem[2:0]) << per;
        prm.offset <= quant_pkg::offset_t'(1) << tsize;
        prm.shift  <= 5'(tsize) + 5'd1;
      end else begin
        prm.scale  <= fwd_scale(rem[2:0]);
        prm.offset <= quant_pkg::offset_t'(rnd) << (fwd_shift - 5'd9);
        prm.shift  <= fwd_shift;
      end
    end
  end

  assert property (@(posedge clk) disable iff (!rst)
    i_load |-> (i_qp <= `QUANT_QP_MAX))
    else $error("qp above the legal range on load");

endmodule

// ==== rtl/coef_in_port.sv ====
module coef_in_port (
  input  logic              clk,
  input  logic              rst,
  input  logic              i_cfg_req,
  output logic              o_cfg_ack,
  input  quant_pkg::qp_t    i_qp,
  input  quant_pkg::tsize_t i_tsize,
  input  logic              i_inter,
  input  logic              i_inverse,
  input  logic              i_coef_req,
  output logic              o_coef_ack,
  input  quant_pkg::coef_t  i_coef,
  output logic              o_load,
  output quant_pkg::qp_t    o_qp,
  output quant_pkg::tsize_t o_tsize,
  output logic              o_inter,
  output logic              o_inverse,
  quant_param_if.monitor    prm,
  output logic              o_valid,
  output quant_pkg::coef_t  o_coef,
  input  logic              i_ready
);

  quant_pkg::hs_state_e cfg_state;
  quant_pkg::hs_state_e coef_state;
  logic                 cfg_take;
  logic                 coef_ok;
  logic                 coef_take;

  assign cfg_take = (cfg_state == quant_pkg::wait_req) && i_cfg_req;

  // coefficients are held back while a new configuration is pending.
  assign coef_ok   = prm.ready && i_ready && !o_load && !cfg_take;
  assign coef_take = (coef_state == quant_pkg::wait_req) && i_coef_req && coef_ok;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      cfg_state <= quant_pkg::wait_req;
      o_cfg_ack <= 1'b0;
      o_load    <= 1'b0;
    end else begin
      o_load <= cfg_take;
      if (cfg_take) begin
        cfg_state <= quant_pkg::wait_release;
      end else if (cfg_state == quant_pkg::wait_release) begin
        // ready still shows the old block during the load cycle.
        if (!o_cfg_ack && prm.ready && !o_load) begin
          o_cfg_ack <= 1'b1;
        end else if (o_cfg_ack && !i_cfg_req) begin
          o_cfg_ack <= 1'b0;
          cfg_state <= quant_pkg::wait_req;
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      coef_state <= quant_pkg::wait_req;
      o_coef_ack <= 1'b0;
      o_valid    <= 1'b0;
    end else begin
      o_valid <= coef_take;
      if (coef_take) begin
        o_coef_ack <= 1'b1;
        coef_state <= quant_pkg::wait_release;
      end else if ((coef_state == quant_pkg::wait_release) && !i_coef_req) begin
        o_coef_ack <= 1'b0;
        coef_state <= quant_pkg::wait_req;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (cfg_take) begin
      o_qp      <= i_qp;
      o_tsize   <= i_tsize;
      o_inter   <= i_inter;
      o_inverse <= i_inverse;
    end
    if (coef_take) begin
      o_coef <= i_coef;
    end
  end

  assert property (@(posedge clk) disable iff (!rst)
    (!o_cfg_ack && !i_cfg_req) |=> !o_cfg_ack)
    else $error("configuration ack raised without req");

endmodule

// ==== rtl/quant_datapath.sv ====
`include "quant_consts.svh"

module quant_datapath (
  input  logic             clk,
  input  logic             rst,
  quant_param_if.sink      prm,
  input  logic             i_valid,
  input  quant_pkg::coef_t i_coef,
  output logic             o_in_ready,
  output logic             o_valid,
  output quant_pkg::coef_t o_coef,
  input  logic             i_out_ready
);

  localparam int coef_max = 2 ** (`QUANT_COEF_W - 1) - 1;
  localparam int coef_min = -(2 ** (`QUANT_COEF_W - 1));

  logic signed [`QUANT_COEF_W:0]     coef_ext;
  logic signed [`QUANT_COEF_W:0]     mag_ext;
  logic signed [`QUANT_COEF_W:0]     scale_ext;
  logic signed [2*`QUANT_COEF_W+1:0] prod;
  logic signed [2*`QUANT_COEF_W+1:0] s1_prod;
  logic                              s1_valid;
  logic                              s1_neg;
  logic                              s1_inverse;
  quant_pkg::offset_t                s1_offset;
  quant_pkg::shift_t                 s1_shift;
  logic signed [2*`QUANT_COEF_W+1:0] sum;
  logic signed [2*`QUANT_COEF_W+1:0] shifted;
  logic signed [2*`QUANT_COEF_W+1:0] res;
  quant_pkg::coef_t                  sat;
  logic                              s2_free;

  assign coef_ext  = {i_coef[`QUANT_COEF_W-1], i_coef};
  assign mag_ext   = i_coef[`QUANT_COEF_W-1] ? -coef_ext : coef_ext;
  assign scale_ext = {1'b0, prm.scale};

  // forward works on the magnitude, inverse on the signed value.
  assign prod = (prm.inverse ? coef_ext : mag_ext) * scale_ext;

  assign sum     = s1_prod + $signed({1'b0, s1_offset});
  assign shifted = sum >>> s1_shift;
  assign res     = (s1_neg && !s1_inverse) ? -shifted : shifted;

  always_comb begin
    if (res > coef_max) begin
      sat = quant_pkg::coef_t'(coef_max);
    end else if (res < coef_min) begin
      sat = quant_pkg::coef_t'(coef_min);
    end else begin
      sat = res[`QUANT_COEF_W-1:0];
    end
  end

  assign s2_free    = !o_valid || i_out_ready;
  assign o_in_ready = !s1_valid;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      s1_valid <= 1'b0;
      o_valid  <= 1'b0;
    end else begin
      if (i_valid) begin
        s1_valid <= 1'b1;
      end else if (s2_free) begin
        s1_valid <= 1'b0;
      end
      if (s2_free) begin
        o_valid <= s1_valid;
      end
    end
  end

  // block parameters travel with the product, so a new block cannot reach older data.
  always_ff @(posedge clk) begin
    if (i_valid) begin
      s1_prod    <= prod;
      s1_neg     <= i_coef[`QUANT_COEF_W-1];
      s1_inverse <= prm.inverse;
      s1_offset  <= prm.offset;
      s1_shift   <= prm.shift;
    end
    if (s1_valid && s2_free) begin
      o_coef <= sat;
    end
  end

  // stage 1 cannot move on while stage 2 is stalled.
  assert property (@(posedge clk) disable iff (!rst)
    (s1_valid && !s2_free) |-> !i_valid)
    else $error("coefficient arrived while the pipeline was stalled");

endmodule

// ==== rtl/coef_out_port.sv ====
module coef_out_port (
  input  logic             clk,
  input  logic             rst,
  input  logic             i_valid,
  input  quant_pkg::coef_t i_coef,
  output logic             o_ready,
  output logic             o_res_req,
  input  logic             i_res_ack,
  output quant_pkg::coef_t o_res
);

  quant_pkg::hs_state_e state;
  logic                 full;
  logic                 take;

  assign o_ready = !full;
  assign take    = i_valid && !full;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      state     <= quant_pkg::wait_req;
      full      <= 1'b0;
      o_res_req <= 1'b0;
    end else begin
      if (take) begin
        full <= 1'b1;
      end
      case (state)
        quant_pkg::wait_req: begin
          // the previous ack has to be gone before the next req.
          if (full && !i_res_ack) begin
            o_res_req <= 1'b1;
            state     <= quant_pkg::wait_release;
          end
        end
        default: begin
          if (o_res_req) begin
            if (i_res_ack) begin
              o_res_req <= 1'b0;
            end
          end else if (!i_res_ack) begin
            full  <= 1'b0;
            state <= quant_pkg::wait_req;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      o_res <= i_coef;
    end
  end

endmodule

// ==== rtl/hevc_quant.sv ====
module hevc_quant (
  input  logic              clk,
  input  logic              rst,
  input  logic              i_cfg_req,
  output logic              o_cfg_ack,
  input  quant_pkg::qp_t    i_qp,
  input  quant_pkg::tsize_t i_tsize,
  input  logic              i_inter,
  input  logic              i_inverse,
  input  logic              i_coef_req,
  output logic              o_coef_ack,
  input  quant_pkg::coef_t  i_coef,
  output logic              o_res_req,
  input  logic              i_res_ack,
  output quant_pkg::coef_t  o_res
);

  quant_param_if prm ();

  logic              load;
  quant_pkg::qp_t    cfg_qp;
  quant_pkg::tsize_t cfg_tsize;
  logic              cfg_inter;
  logic              cfg_inverse;
  logic              in_valid;
  quant_pkg::coef_t  in_coef;
  logic              in_ready;
  logic              out_valid;
  quant_pkg::coef_t  out_coef;
  logic              out_ready;

  coef_in_port u_in (
    .clk        (clk),
    .rst        (rst),
    .i_cfg_req  (i_cfg_req),
    .o_cfg_ack  (o_cfg_ack),
    .i_qp       (i_qp),
    .i_tsize    (i_tsize),
    .i_inter    (i_inter),
    .i_inverse  (i_inverse),
    .i_coef_req (i_coef_req),
    .o_coef_ack (o_coef_ack),
    .i_coef     (i_coef),
    .o_load     (load),
    .o_qp       (cfg_qp),
    .o_tsize    (cfg_tsize),
    .o_inter    (cfg_inter),
    .o_inverse  (cfg_inverse),
    .prm        (prm),
    .o_valid    (in_valid),
    .o_coef     (in_coef),
    .i_ready    (in_ready)
  );

  qp_scale_gen u_qp (
    .clk       (clk),
    .rst       (rst),
    .i_load    (load),
    .i_qp      (cfg_qp),
    .i_tsize   (cfg_tsize),
    .i_inter   (cfg_inter),
    .i_inverse (cfg_inverse),
    .prm       (prm)
  );

  quant_datapath u_dp (
    .clk         (clk),
    .rst         (rst),
    .prm         (prm),
    .i_valid     (in_valid),
    .i_coef      (in_coef),
    .o_in_ready  (in_ready),
    .o_valid     (out_valid),
    .o_coef      (out_coef),
    .i_out_ready (out_ready)
  );

  coef_out_port u_out (
    .clk       (clk),
    .rst       (rst),
    .i_valid   (out_valid),
    .i_coef    (out_coef),
    .o_ready   (out_ready),
    .o_res_req (o_res_req),
    .i_res_ack (i_res_ack),
    .o_res     (o_res)
  );

endmodule

// ==== test/tb_clock.sv ====
module tb_clock (
  output logic o_clk
);

  // period of 10.
  initial begin
    o_clk = 1'b0;
    forever begin
      #5 o_clk = ~o_clk;
    end
  end

endmodule

// ==== test/tb_checker.sv ====
module tb_checker (
  input  logic             i_clk,
  input  logic             i_rst,
  input  logic             i_res_req,
  input  quant_pkg::coef_t i_res,
  input  int               i_max_delay,
  output logic             o_res_ack
);

  quant_pkg::coef_t exp_q[$];
  quant_pkg::coef_t expected;
  quant_pkg::coef_t prev_res;
  logic             prev_req;
  logic             pending;
  int               delay;
  int               errors;
  int               checked;

  task automatic compare_result();
    if (exp_q.size() == 0) begin
      errors++;
      $display("extra result %h arrived with nothing expected", i_res);
    end else begin
      expected = exp_q.pop_front();
      checked++;
      if (i_res !== expected) begin
        errors++;
        $display("mismatch o_res: got %h, expected %h", i_res, expected);
      end
    end
  endtask

  // outputs are sampled on the falling edge, where they are stable.
  initial begin
    o_res_ack = 1'b0;
    prev_req  = 1'b0;
    prev_res  = '0;
    pending   = 1'b0;
    delay     = 0;
    errors    = 0;
    checked   = 0;
    forever begin
      @(negedge i_clk);
      if (i_rst) begin
        if (prev_req && i_res_req && (i_res !== prev_res)) begin
          errors++;
          $display("result value changed while its req was high");
        end
        if (prev_req && !i_res_req && !o_res_ack) begin
          errors++;
          $display("result req fell before it was acknowledged");
        end
        if (!prev_req && i_res_req && o_res_ack) begin
          errors++;
          $display("result req rose while the previous ack was still high");
        end
        if (i_res_req && !o_res_ack) begin
          if (!pending) begin
            pending = 1'b1;
            delay   = int'($urandom_range(i_max_delay, 0));
          end
          if (delay == 0) begin
            compare_result();
            o_res_ack = 1'b1;
            pending   = 1'b0;
          end else begin
            delay--;
          end
        end else if (!i_res_req && o_res_ack) begin
          // ack is released after a random delay of its own.
          if (!pending) begin
            pending = 1'b1;
            delay   = int'($urandom_range(i_max_delay, 0));
          end
          if (delay == 0) begin
            o_res_ack = 1'b0;
            pending   = 1'b0;
          end else begin
            delay--;
          end
        end
      end
      prev_req = i_res_req;
      prev_res = i_res;
    end
  end

endmodule

// ==== test/tb_hevc_quant.sv ====
module tb_hevc_quant;

  localparam int qp_list [3] = '{0, 22, 51};
  localparam int edge_list [5] = '{-32768, -1, 0, 1, 32767};
  localparam int fwd_q [6] = '{26214, 23302, 20560, 18396, 16384, 14564};
  localparam int inv_q [6] = '{40, 45, 51, 57, 64, 72};
  localparam int rnd_per_block = 8;
  localparam int slow_blocks = 4;
  localparam int n_blocks = 48 + slow_blocks;
  localparam int n_coefs = n_blocks * (1 + 5 + rnd_per_block);
  localparam int watchdog_cycles = n_coefs * 200 + n_blocks * 100;

  logic              clk;
  logic              rst;
  logic              i_cfg_req;
  logic              o_cfg_ack;
  quant_pkg::qp_t    i_qp;
  quant_pkg::tsize_t i_tsize;
  logic              i_inter;
  logic              i_inverse;
  logic              i_coef_req;
  logic              o_coef_ack;
  quant_pkg::coef_t  i_coef;
  logic              o_res_req;
  logic              i_res_ack;
  quant_pkg::coef_t  o_res;

  int errors;
  int ack_delay_max;
  int cur_qp;
  int cur_ts;
  int cur_inter;
  int cur_inv;

  tb_clock clk_gen (.o_clk(clk));

  hevc_quant dut (
    .clk        (clk),
    .rst        (rst),
    .i_cfg_req  (i_cfg_req),
    .o_cfg_ack  (o_cfg_ack),
    .i_qp       (i_qp),
    .i_tsize    (i_tsize),
    .i_inter    (i_inter),
    .i_inverse  (i_inverse),
    .i_coef_req (i_coef_req),
    .o_coef_ack (o_coef_ack),
    .i_coef     (i_coef),
    .o_res_req  (o_res_req),
    .i_res_ack  (i_res_ack),
    .o_res      (o_res)
  );

  tb_checker chk (
    .i_clk       (clk),
    .i_rst       (rst),
    .i_res_req   (o_res_req),
    .i_res       (o_res),
    .i_max_delay (ack_delay_max),
    .o_res_ack   (i_res_ack)
  );

  // forward rounds the magnitude, inverse shifts the signed product.
  function automatic quant_pkg::coef_t quant_ref(input int c, input int qp, input int ts,
                                                 input int inter, input int inv);
    int     p;
    int     r;
    int     shift;
    longint q;
    longint off;
    longint v;
    p = qp / 6;
    r = qp % 6;
    if (inv != 0) begin
      q     = longint'(inv_q[r]) << p;
      shift = ts + 1;
      off   = longint'(1) << (shift - 1);
      v     = (longint'(c) * q + off) >>> shift;
    end else begin
      q     = longint'(fwd_q[r]);
      shift = 19 - ts + p;
      off   = longint'((inter != 0) ? 85 : 171) << (shift - 9);
      v     = (longint'((c < 0) ? -c : c) * q + off) >>> shift;
      if (c < 0) begin
        v = -v;
      end
    end
    if (v > 32767) begin
      v = 32767;
    end else if (v < -32768) begin
      v = -32768;
    end
    return quant_pkg::coef_t'(v);
  endfunction

  function automatic int rand_coef(input bit big);
    if (big) begin
      return int'($urandom_range(65535, 0)) - 32768;
    end else begin
      return int'($urandom_range(1023, 0)) - 512;
    end
  endfunction

  task automatic send_coef(input int c);
    @(negedge clk);
    chk.exp_q.push_back(quant_ref(c, cur_qp, cur_ts, cur_inter, cur_inv));
    i_coef     = quant_pkg::coef_t'(c);
    i_coef_req = 1'b1;
    while (!o_coef_ack) @(negedge clk);
    i_coef_req = 1'b0;
    while (o_coef_ack) @(negedge clk);
  endtask

  // a coefficient is raised together with the configuration and must wait for its ack.
  task automatic configure(input int qp, input int ts, input int inter, input int inv,
                           input int c);
    int cfg_ph;
    int coef_ph;
    cfg_ph  = 0;
    coef_ph = 0;
    @(negedge clk);
    cur_qp    = qp;
    cur_ts    = ts;
    cur_inter = inter;
    cur_inv   = inv;
    chk.exp_q.push_back(quant_ref(c, qp, ts, inter, inv));
    i_qp       = quant_pkg::qp_t'(qp);
    i_tsize    = quant_pkg::tsize_t'(ts);
    i_inter    = (inter != 0);
    i_inverse  = (inv != 0);
    i_coef     = quant_pkg::coef_t'(c);
    i_cfg_req  = 1'b1;
    i_coef_req = 1'b1;
    while ((cfg_ph < 2) || (coef_ph < 2)) begin
      @(negedge clk);
      if ((cfg_ph == 0) && o_cfg_ack) begin
        i_cfg_req = 1'b0;
        cfg_ph    = 1;
      end else if ((cfg_ph == 1) && !o_cfg_ack) begin
        cfg_ph = 2;
      end
      if ((coef_ph == 0) && o_coef_ack) begin
        if (cfg_ph == 0) begin
          errors++;
          $display("coefficient was accepted before the configuration ack");
        end
        i_coef_req = 1'b0;
        coef_ph    = 1;
      end else if ((coef_ph == 1) && !o_coef_ack) begin
        coef_ph = 2;
      end
    end
  endtask

  task automatic run_block(input int qp, input int ts, input int inter, input int inv);
    configure(qp, ts, inter, inv, rand_coef(1'b1));
    for (int i = 0; i < 5; i++) begin
      send_coef(edge_list[i]);
    end
    for (int i = 0; i < rnd_per_block; i++) begin
      send_coef(rand_coef(i[0]));
    end
  endtask

  initial begin
    int guard;
    void'($urandom(18106));
    errors        = 0;
    ack_delay_max = 2;
    rst           = 1'b0;
    i_cfg_req     = 1'b0;
    i_qp          = '0;
    i_tsize       = '0;
    i_inter       = 1'b0;
    i_inverse     = 1'b0;
    i_coef_req    = 1'b0;
    i_coef        = '0;
    repeat (8) @(negedge clk);
    rst = 1'b1;

    for (int inv = 0; inv < 2; inv++) begin
      for (int qi = 0; qi < 3; qi++) begin
        for (int ts = 0; ts < 4; ts++) begin
          for (int inter = 0; inter < 2; inter++) begin
            run_block(qp_list[qi], ts, inter, inv);
          end
        end
      end
    end

    // slow acks keep the output buffer full and stall the pipeline.
    ack_delay_max = 15;
    for (int i = 0; i < slow_blocks; i++) begin
      run_block(int'($urandom_range(51, 0)), i, i % 2, i / 2);
    end

    guard = 0;
    while ((chk.exp_q.size() != 0) && (guard < 1000)) begin
      @(negedge clk);
      guard++;
    end
    if (chk.exp_q.size() != 0) begin
      errors++;
      $display("%0d results never arrived", chk.exp_q.size());
    end
    repeat (20) @(negedge clk);

    $display("checked %0d results, %0d errors", chk.checked, errors + chk.errors);
    if ((errors + chk.errors) == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("timeout after %0d cycles, checked %0d results, %0d errors",
             watchdog_cycles, chk.checked, errors + chk.errors);
    $display("Some tests failed");
    $finish;
  end

endmodule

// ==== hevc_quant.f ====
+incdir+rtl
rtl/quant_pkg.sv
rtl/quant_param_if.sv
rtl/qp_scale_gen.sv
rtl/coef_in_port.sv
rtl/quant_datapath.sv
rtl/coef_out_port.sv
rtl/hevc_quant.sv
test/tb_clock.sv
test/tb_checker.sv
test/tb_hevc_quant.sv

// ==== Makefile ====
TOP = tb_hevc_quant

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal -f hevc_quant.f \
		--top-module $(TOP) -Mdir obj_dir

run: compile
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir
